// File: design/ks10Pkg.sv
// Bus widths, address map and bus structs shared by all blocks
// Only the low memWords of physical memory are fitted; IO map is minimal

`default_nettype none

package ks10Pkg;

   //////////////////////////////////////////////////////////////////////
   // Bus widths
   //////////////////////////////////////////////////////////////////////

   localparam int dataWidth = 36;             // KS10 word
   localparam int addrWidth = 22;             // Physical address bits 14..35

   // Main memory
   localparam int memWords    = 1024;
   localparam int memAddrBits = $clog2(memWords);

   //////////////////////////////////////////////////////////////////////
   // IO address map
   //////////////////////////////////////////////////////////////////////

   localparam logic [addrWidth-1:0] ioBaseCons = 22'o0200000;   // Console page
   localparam int                   consRegs   = 3;
   localparam logic [1:0]           consTxData = 2'd0;          // Write starts char
   localparam logic [1:0]           consRxData = 2'd1;          // Last received char
   localparam logic [1:0]           consStatus = 2'd2;          // {rxValid, txBusy}

   localparam logic [addrWidth-1:0] ioBaseUba   = 22'o1763000;  // Adapter map page
   localparam int                   ubaRegs     = 8;
   localparam int                   ubaAddrBits = $clog2(ubaRegs);

   // Console serial line
   localparam int clksPerBit   = 4;
   localparam int clkDivBits   = $clog2(clksPerBit);
   localparam int rxMidBit     = clksPerBit / 2 - 1;    // Sample point in a bit
   localparam int charBits     = 8;
   localparam int frameBits    = charBits + 2;          // Start + data + stop
   localparam int frameCntBits = $clog2(frameBits);

   //////////////////////////////////////////////////////////////////////
   // Bus structs
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                 read;
      logic                 write;
      logic                 io;                         // IO space, not memory
      logic [addrWidth-1:0] addr;
      logic [dataWidth-1:0] data;                       // Write data
   } busReqT;

   typedef struct packed {
      logic                 ack;
      logic [dataWidth-1:0] data;                       // Zero unless acking a read
   } busRspT;

endpackage

`default_nettype wire

// File: design/resetSync.sv
// Reset asserts at once and releases two clocks after rstN rises

`timescale 1ns/10ps
`default_nettype none

module resetSync (
   input  wire  clk,
   input  wire  rstN,             // Raw board reset
   output logic rstSyncN          // Clean reset for the rest of the system
);

   logic [1:0] syncChain;         // Two-flop release chain

   // Async clear, sync release
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         syncChain <= 2'b00;
      end else begin
         syncChain <= {syncChain[0], 1'b1};
      end
   end

   assign rstSyncN = syncChain[1];

endmodule

`default_nettype wire

// File: design/busArbiter.sv
// Responses are ORed; only one responder may ack in a cycle
// nxmIrq flags a memory request that got no ack, in the response cycle

`timescale 1ns/10ps
`default_nettype none

module busArbiter
   import ks10Pkg::*;
(
   input  wire    clk,
   input  wire    rstN,
   input  wire    busReqT busReq,
   input  wire    busRspT memRsp,
   input  wire    busRspT consRsp,
   input  wire    busRspT ubaRsp,
   output busRspT busRsp,
   output logic   nxmIrq
);

   logic memCycle;                // Last cycle carried a memory request

   //////////////////////////////////////////////////////////////////////
   // Track memory requests in flight
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         memCycle <= 1'b0;
      end else begin
         memCycle <= (busReq.read | busReq.write) & ~busReq.io;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Response merge
   //////////////////////////////////////////////////////////////////////

   // Idle responders drive zero data, so a plain OR is enough
   always_comb begin
      busRsp.ack  = memRsp.ack  | consRsp.ack  | ubaRsp.ack;
      busRsp.data = memRsp.data | consRsp.data | ubaRsp.data;
   end

   // Memory access with nobody answering
   assign nxmIrq = memCycle & ~busRsp.ack;

endmodule

`default_nettype wire

// File: design/memController.sv
// Only addresses below memWords are fitted; others are left unacked
// Contents come up undefined after reset

`timescale 1ns/10ps
`default_nettype none

module memController
   import ks10Pkg::*;
(
   input  wire    clk,
   input  wire    rstN,
   input  wire    busReqT busReq,
   output busRspT memRsp
);

   logic [dataWidth-1:0]   memArray [memWords];   // Word storage
   logic [memAddrBits-1:0] wordAddr;
   logic                   hit;                   // Request decodes to memory
   logic                   rspAck;
   logic                   rspRead;               // Acked access was a read
   logic [dataWidth-1:0]   rdData;

   //////////////////////////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////////////////////////

   assign wordAddr = busReq.addr[memAddrBits-1:0];

   assign hit = (busReq.read | busReq.write)
              & ~busReq.io
              & (busReq.addr < addrWidth'(memWords));   // Range check

   //////////////////////////////////////////////////////////////////////
   // Array
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (hit & busReq.write) begin
         memArray[wordAddr] <= busReq.data;
      end
      if (hit & busReq.read) begin
         rdData <= memArray[wordAddr];            // Registered read
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Response, one clock after the request
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rspAck  <= 1'b0;
         rspRead <= 1'b0;
      end else begin
         rspAck  <= hit;
         rspRead <= hit & busReq.read;
      end
   end

   assign memRsp.ack  = rspAck;
   assign memRsp.data = rspRead ? rdData : '0;    // Zero on writes and idle

endmodule

`default_nettype wire

// File: design/consoleUart.sv
// Console registers plus an 8N1 serial line at clksPerBit clocks per bit
// A transmit write while busy is acked and dropped; no framing error flag

`timescale 1ns/10ps
`default_nettype none

module consoleUart
   import ks10Pkg::*;
(
   input  wire    clk,
   input  wire    rstN,
   input  wire    busReqT busReq,
   output busRspT consRsp,
   input  wire    conRxd,          // Serial in, asynchronous
   output logic   conTxd           // Serial out, idles high
);

   logic [addrWidth-1:0]    regOff;        // Offset into console page
   logic                    sel;
   logic                    txStart, rxRead;
   logic                    rspAck;
   logic [dataWidth-1:0]    rspData;

   logic [frameBits-1:0]    txShift;       // {stop, data, start}
   logic [clkDivBits-1:0]   txDiv;
   logic [frameCntBits-1:0] txBitCnt;
   logic                    txBusy;

   logic [2:0]              rxSync;        // Two sync flops + edge history
   logic                    rxLine, rxEdge, rxSample;
   logic                    rxActive, rxValid;
   logic [clkDivBits-1:0]   rxDiv;
   logic [frameCntBits-1:0] rxBitCnt;
   logic [charBits-1:0]     rxShift, rxData;

   //////////////////////////////////////////////////////////////////////
   // Bus decode and registers
   //////////////////////////////////////////////////////////////////////

   assign regOff = busReq.addr - ioBaseCons;
   assign sel    = busReq.io & (busReq.read | busReq.write)
                 & (busReq.addr >= ioBaseCons)
                 & (regOff < addrWidth'(consRegs));

   assign txStart = sel & busReq.write & (regOff[1:0] == consTxData) & ~txBusy;
   assign rxRead  = sel & busReq.read  & (regOff[1:0] == consRxData);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rspAck  <= 1'b0;
         rspData <= '0;
      end else begin
         rspAck  <= sel;                   // Writes to any reg are acked
         rspData <= '0;
         if (sel & busReq.read) begin
            case (regOff[1:0])
               consRxData: rspData <= {{(dataWidth-charBits){1'b0}}, rxData};
               consStatus: rspData <= {{(dataWidth-2){1'b0}}, rxValid, txBusy};
               default:    rspData <= '0;  // Tx data is write only
            endcase
         end
      end
   end

   assign consRsp.ack  = rspAck;
   assign consRsp.data = rspData;

   //////////////////////////////////////////////////////////////////////
   // Transmitter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         txBusy   <= 1'b0;
         txDiv    <= '0;
         txBitCnt <= '0;
         txShift  <= '1;
      end else if (txStart) begin
         txShift  <= {1'b1, busReq.data[charBits-1:0], 1'b0};
         txBusy   <= 1'b1;
         txDiv    <= '0;
         txBitCnt <= '0;
      end else if (txBusy) begin
         if (txDiv == clkDivBits'(clksPerBit - 1)) begin   // End of a bit
            txDiv    <= '0;
            txShift  <= {1'b1, txShift[frameBits-1:1]};    // LSB first
            txBitCnt <= txBitCnt + 1'b1;
            if (txBitCnt == frameCntBits'(frameBits - 1)) begin
               txBusy <= 1'b0;                             // Stop bit done
            end
         end else begin
            txDiv <= txDiv + 1'b1;
         end
      end
   end

   assign conTxd = txBusy ? txShift[0] : 1'b1;

   //////////////////////////////////////////////////////////////////////
   // Receiver
   //////////////////////////////////////////////////////////////////////

   assign rxLine   = rxSync[1];
   assign rxEdge   = rxSync[2] & ~rxSync[1];              // Falling edge = start
   assign rxSample = rxActive & (rxDiv == clkDivBits'(rxMidBit));

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rxSync   <= 3'b111;
         rxActive <= 1'b0;
         rxDiv    <= '0;
         rxBitCnt <= '0;
         rxValid  <= 1'b0;
         rxData   <= '0;
      end else begin
         rxSync <= {rxSync[1:0], conRxd};
         if (rxRead) begin
            rxValid <= 1'b0;
         end
         if (!rxActive) begin
            if (rxEdge) begin
               rxActive <= 1'b1;
               rxDiv    <= '0;
               rxBitCnt <= '0;
            end
         end else begin
            rxDiv <= (rxDiv == clkDivBits'(clksPerBit - 1)) ? '0 : rxDiv + 1'b1;
            if (rxSample) begin
               rxBitCnt <= rxBitCnt + 1'b1;
               if (rxBitCnt == '0 && rxLine) begin
                  rxActive <= 1'b0;                       // Glitch, not a start
               end else if (rxBitCnt == frameCntBits'(frameBits - 1)) begin
                  rxActive <= 1'b0;                       // Stop bit sampled
                  rxValid  <= 1'b1;                       // Wins over a read
                  rxData   <= rxShift;
               end
            end
         end
      end
   end

   // Data bits shift in LSB first
   always_ff @(posedge clk) begin
      if (rxSample && rxBitCnt != '0 && rxBitCnt != frameCntBits'(frameBits - 1)) begin
         rxShift <= {rxLine, rxShift[charBits-1:1]};
      end
   end

endmodule

`default_nettype wire

// File: design/unibusAdapter.sv
// Adapter mapping registers only; no Unibus devices behind them
// Registers are written as whole words and clear on reset

`timescale 1ns/10ps
`default_nettype none

module unibusAdapter
   import ks10Pkg::*;
(
   input  wire    clk,
   input  wire    rstN,
   input  wire    busReqT busReq,
   output busRspT ubaRsp
);

   logic [dataWidth-1:0]   mapRegs [ubaRegs];     // Page mapping registers
   logic [addrWidth-1:0]   regOff;
   logic [ubaAddrBits-1:0] regIdx;
   logic                   sel;                   // Request hits the page
   logic                   rspAck;
   logic [dataWidth-1:0]   rspData;

   //////////////////////////////////////////////////////////////////////
   // Page decode
   //////////////////////////////////////////////////////////////////////

   assign regOff = busReq.addr - ioBaseUba;
   assign regIdx = regOff[ubaAddrBits-1:0];
   assign sel    = busReq.io & (busReq.read | busReq.write)
                 & (busReq.addr >= ioBaseUba)
                 & (regOff < addrWidth'(ubaRegs));

   //////////////////////////////////////////////////////////////////////
   // Registers and response
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < ubaRegs; i++) begin
            mapRegs[i] <= '0;
         end
         rspAck  <= 1'b0;
         rspData <= '0;
      end else begin
         rspAck  <= sel;
         rspData <= (sel & busReq.read) ? mapRegs[regIdx] : '0;
         if (sel & busReq.write) begin
            mapRegs[regIdx] <= busReq.data;       // Whole-word write
         end
      end
   end

   assign ubaRsp.ack  = rspAck;
   assign ubaRsp.data = rspData;

endmodule

`default_nettype wire

// File: design/ks10Top.sv
// System bus top; the CPU is replaced by the busReq master port
// Every request goes to all three responders, one clock to respond

`timescale 1ns/10ps
`default_nettype none

module ks10Top
   import ks10Pkg::*;
(
   input  wire    clk,
   input  wire    rstN,            // Raw reset
   input  wire    busReqT busReq,  // From bus master
   output busRspT busRsp,          // Merged response
   output logic   nxmIrq,          // Nonexistent memory
   input  wire    conRxd,          // Console serial in
   output logic   conTxd           // Console serial out
);

   logic   rstSyncN;               // Synchronized reset
   busRspT memRsp;                 // Memory response
   busRspT consRsp;                // Console response
   busRspT ubaRsp;                 // Adapter response

   //////////////////////////////////////////////////////////////////////
   // Reset
   //////////////////////////////////////////////////////////////////////

   resetSync uResetSync (
      .clk       (clk),
      .rstN      (rstN),
      .rstSyncN  (rstSyncN)
   );

   //////////////////////////////////////////////////////////////////////
   // Responders
   //////////////////////////////////////////////////////////////////////

   memController uMem (
      .clk       (clk),
      .rstN      (rstSyncN),
      .busReq    (busReq),
      .memRsp    (memRsp)
   );

   consoleUart uCons (
      .clk       (clk),
      .rstN      (rstSyncN),
      .busReq    (busReq),
      .consRsp   (consRsp),
      .conRxd    (conRxd),
      .conTxd    (conTxd)
   );

   unibusAdapter uUba (
      .clk       (clk),
      .rstN      (rstSyncN),
      .busReq    (busReq),
      .ubaRsp    (ubaRsp)
   );

   // Merge and NXM detect
   busArbiter uArb (
      .clk       (clk),
      .rstN      (rstSyncN),
      .busReq    (busReq),
      .memRsp    (memRsp),
      .consRsp   (consRsp),
      .ubaRsp    (ubaRsp),
      .busRsp    (busRsp),
      .nxmIrq    (nxmIrq)
   );

endmodule

`default_nettype wire

// File: tests/busProtocol_asserts.sv
// Bus handshake rules, checked every clock once the synchronized reset is gone
// Bound into ks10Top so each responder's own response is visible

`timescale 1ns/10ps
`default_nettype none

module busProtocol_asserts
   import ks10Pkg::*;
(
   input wire         clk,
   input wire         rstN,
   input wire busReqT busReq,
   input wire busRspT memRsp,
   input wire busRspT consRsp,
   input wire busRspT ubaRsp,
   input wire busRspT busRsp,
   input wire         nxmIrq
);

   // Master never reads and writes at once
   reqExclusive: assert property (@(posedge clk) disable iff (!rstN)
      !(busReq.read && busReq.write))
      else $error("read and write high in the same cycle");

   // Address decodes never overlap
   singleAck: assert property (@(posedge clk) disable iff (!rstN)
      $onehot0({memRsp.ack, consRsp.ack, ubaRsp.ack}))
      else $error("more than one responder acked");

   idleDataZero: assert property (@(posedge clk) disable iff (!rstN)
      !busRsp.ack |-> (busRsp.data == '0))
      else $error("response data nonzero without ack");

   // Fitted memory always answers, so never NXM
   memNoNxm: assert property (@(posedge clk) disable iff (!rstN)
      ((busReq.read || busReq.write) && !busReq.io
       && (busReq.addr < addrWidth'(memWords))) |=> (busRsp.ack && !nxmIrq))
      else $error("fitted memory access got no ack or raised nxmIrq");

endmodule

bind ks10Top busProtocol_asserts uBusAsserts (
   .clk      (clk),
   .rstN     (rstSyncN),
   .busReq   (busReq),
   .memRsp   (memRsp),
   .consRsp  (consRsp),
   .ubaRsp   (ubaRsp),
   .busRsp   (busRsp),
   .nxmIrq   (nxmIrq)
);

`default_nettype wire

// File: tests/ks10Tb.sv
// Random bus traffic checked against a model of memory, console and adapter
// Memory reads only target words already written; tx writes only in test 4

`timescale 1ns/10ps
`default_nettype none

module ks10Tb
   import ks10Pkg::*;
();

   localparam int timeoutCycles = 400;

   typedef struct packed {
      logic                 ack;
      logic                 nxm;
      logic                 chkData;          // Compare data too
      logic [dataWidth-1:0] data;
   } expectT;

   logic   clk;
   logic   rstN;
   busReqT busReq;
   busRspT busRsp;
   logic   nxmIrq;
   logic   conRxd;
   logic   conTxd;

   // Reference model
   logic [dataWidth-1:0] memModel [memWords];
   bit                   memWritten [memWords];
   logic [dataWidth-1:0] ubaModel [ubaRegs];
   logic [charBits-1:0]  lastRxChar;
   expectT               expectQ [$];       // One entry per issued cycle
   logic [dataWidth-1:0] lastData;          // Data seen at the last check
   logic                 frameDone;
   int                   errorCount, checkCount, testCount, failedTests;

   ks10Top dut_i (
      .clk     (clk),
      .rstN    (rstN),
      .busReq  (busReq),
      .busRsp  (busRsp),
      .nxmIrq  (nxmIrq),
      .conRxd  (conRxd),
      .conTxd  (conTxd)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                // 40 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [dataWidth-1:0] randWord();
      return {4'($urandom), $urandom};
   endfunction

   function automatic busReqT makeReq(logic rd, logic wr, logic io,
                                      logic [addrWidth-1:0] addr,
                                      logic [dataWidth-1:0] data);
      busReqT req;
      req.read  = rd;
      req.write = wr;
      req.io    = io;
      req.addr  = addr;
      req.data  = data;
      return req;
   endfunction

   // Console and adapter pages are the only IO that answers
   function automatic logic isMapped(logic [addrWidth-1:0] addr);
      return (addr >= ioBaseCons && addr < ioBaseCons + addrWidth'(consRegs))
          || (addr >= ioBaseUba && addr < ioBaseUba + addrWidth'(ubaRegs));
   endfunction

   // Compare the response to the request of the previous cycle
   task automatic checkPending();
      expectT exp;
      if (expectQ.size() != 0) begin
         exp      = expectQ.pop_front();
         lastData = busRsp.data;
         checkCount++;
         if (busRsp.ack !== exp.ack) begin
            $display("Fail busRsp.ack: got %h expected %h at %0t", busRsp.ack, exp.ack, $time);
            errorCount++;
         end
         if (nxmIrq !== exp.nxm) begin
            $display("Fail nxmIrq: got %h expected %h at %0t", nxmIrq, exp.nxm, $time);
            errorCount++;
         end
         if (exp.chkData && busRsp.data !== exp.data) begin
            $display("Fail busRsp.data: got %h expected %h at %0t",
                     busRsp.data, exp.data, $time);
            errorCount++;
         end
      end
   endtask

   task automatic issue(busReqT req, logic expAck, logic expNxm, logic chk,
                        logic [dataWidth-1:0] expData);
      expectT exp;
      @(negedge clk);
      checkPending();
      busReq      = req;                     // Falling edge drive
      exp.ack     = expAck;
      exp.nxm     = expNxm;
      exp.chkData = chk;
      exp.data    = expData;
      expectQ.push_back(exp);
   endtask

   task automatic idleCycle();
      issue('0, 1'b0, 1'b0, 1'b1, '0);
   endtask

   task automatic readReg(input logic [addrWidth-1:0] addr,
                          output logic [dataWidth-1:0] data);
      issue(makeReq(1'b1, 1'b0, 1'b1, addr, '0), 1'b1, 1'b0, 1'b0, '0);
      idleCycle();
      data = lastData;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Random operations
   //////////////////////////////////////////////////////////////////////

   task automatic randomMemOp();
      logic [memAddrBits-1:0] idx;
      logic [addrWidth-1:0]   addr;
      logic [dataWidth-1:0]   data;
      idx  = memAddrBits'($urandom % memWords);
      addr = addrWidth'(idx);
      if (!memWritten[idx] || $urandom % 2 == 0) begin
         data            = randWord();
         memModel[idx]   = data;
         memWritten[idx] = 1'b1;
         issue(makeReq(1'b0, 1'b1, 1'b0, addr, data), 1'b1, 1'b0, 1'b1, '0);
      end else begin
         issue(makeReq(1'b1, 1'b0, 1'b0, addr, '0), 1'b1, 1'b0, 1'b1, memModel[idx]);
      end
   endtask

   task automatic randomUbaOp();
      logic [ubaAddrBits-1:0] idx;
      logic [addrWidth-1:0]   addr;
      logic [dataWidth-1:0]   data;
      idx  = ubaAddrBits'($urandom % ubaRegs);
      addr = ioBaseUba + addrWidth'(idx);
      if ($urandom % 2 == 0) begin
         data          = randWord();
         ubaModel[idx] = data;                // Whole-word write
         issue(makeReq(1'b0, 1'b1, 1'b1, addr, data), 1'b1, 1'b0, 1'b1, '0);
      end else begin
         issue(makeReq(1'b1, 1'b0, 1'b1, addr, '0), 1'b1, 1'b0, 1'b1, ubaModel[idx]);
      end
   endtask

   // Beyond fitted memory, NXM in the response cycle
   task automatic randomNxmOp();
      logic [addrWidth-1:0] addr;
      logic                 rd;
      addr = addrWidth'(memWords) + addrWidth'($urandom % ((1 << addrWidth) - memWords));
      rd   = 1'($urandom);
      issue(makeReq(rd, ~rd, 1'b0, addr, randWord()), 1'b0, 1'b1, 1'b1, '0);
   endtask

   task automatic randomUnmappedIo();
      logic [addrWidth-1:0] addr;
      logic                 rd;
      do begin
         addr = addrWidth'($urandom);
      end while (isMapped(addr));
      rd = 1'($urandom);
      issue(makeReq(rd, ~rd, 1'b1, addr, randWord()), 1'b0, 1'b0, 1'b1, '0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Serial line
   //////////////////////////////////////////////////////////////////////

   task automatic sendFrame(logic [charBits-1:0] ch);
      logic [frameBits-1:0] bits;
      bits = {1'b1, ch, 1'b0};               // Stop, data, start
      for (int i = 0; i < frameBits; i++) begin
         for (int j = 0; j < clksPerBit; j++) begin
            idleCycle();
            if (j == 0) conRxd = bits[i];
         end
      end
   endtask

   // Mid-bit sampling of conTxd
   task automatic captureFrame(output logic [charBits-1:0] ch);
      int waitCnt;
      waitCnt = 0;
      ch      = '0;
      while (conTxd !== 1'b0 && waitCnt < timeoutCycles) begin
         @(negedge clk);
         waitCnt++;
      end
      if (conTxd !== 1'b0) begin
         $display("Timeout waiting for a start bit on conTxd");
         errorCount++;
      end else begin
         repeat (clksPerBit / 2) @(negedge clk);
         for (int i = 0; i < charBits; i++) begin
            repeat (clksPerBit) @(negedge clk);
            ch[i] = conTxd;
         end
         repeat (clksPerBit) @(negedge clk);
         if (conTxd !== 1'b1) begin
            $display("Stop bit missing on conTxd");
            errorCount++;
         end
         frameDone = 1'b1;
      end
   endtask

   task automatic finishTest(string name, int errorsBefore);
      testCount++;
      if (errorCount == errorsBefore) begin
         $display("Test %0d %s: ok", testCount, name);
      end else begin
         failedTests++;
         $display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int                   errs;
      int                   polls;
      int                   kind;
      logic [dataWidth-1:0] st;
      logic [charBits-1:0]  txChar, gotChar, rxChar;
      logic [1:0]           off;
      void'($urandom(32'h54f6));
      errorCount  = 0;
      checkCount  = 0;
      testCount   = 0;
      failedTests = 0;
      frameDone   = 1'b0;
      lastRxChar  = '0;
      rstN        = 1'b0;
      busReq      = '0;
      conRxd      = 1'b1;                    // Line idle
      repeat (4) @(negedge clk);
      rstN = 1'b1;
      repeat (3) @(negedge clk);             // Sync release takes 2 clocks

      // 1 memory
      errs = errorCount;
      repeat (200) randomMemOp();
      idleCycle();
      finishTest("memory read/write", errs);

      // 2 NXM and unmapped IO, alternating
      errs = errorCount;
      for (int i = 0; i < 40; i++) begin
         if (i % 2 == 0) randomNxmOp();
         else randomUnmappedIo();
      end
      idleCycle();
      finishTest("nxm and unmapped io", errs);

      // 3 adapter, reset values first
      errs = errorCount;
      for (int i = 0; i < ubaRegs; i++) begin
         ubaModel[i] = '0;
         issue(makeReq(1'b1, 1'b0, 1'b1, ioBaseUba + addrWidth'(i), '0),
               1'b1, 1'b0, 1'b1, '0);
      end
      repeat (100) randomUbaOp();
      idleCycle();
      finishTest("adapter registers", errs);

      // 4 console transmit
      errs   = errorCount;
      txChar = 8'($urandom);
      readReg(ioBaseCons + addrWidth'(consStatus), st);
      if (st !== '0) begin
         $display("Fail status: got %h expected %h", st, 36'h0);
         errorCount++;
      end
      fork
         captureFrame(gotChar);
         begin
            issue(makeReq(1'b0, 1'b1, 1'b1, ioBaseCons, dataWidth'(txChar)),
                  1'b1, 1'b0, 1'b1, '0);
            // Dropped while busy
            issue(makeReq(1'b0, 1'b1, 1'b1, ioBaseCons, dataWidth'(~txChar)),
                  1'b1, 1'b0, 1'b1, '0);
            readReg(ioBaseCons + addrWidth'(consStatus), st);
            if (st[0] !== 1'b1) begin
               $display("Fail status busy: got %h expected %h", st[0], 1'b1);
               errorCount++;
            end
            polls = 0;
            while (st[0] === 1'b1 && polls < timeoutCycles) begin
               readReg(ioBaseCons + addrWidth'(consStatus), st);
               polls++;
            end
            if (st[0] !== 1'b0) begin
               $display("Timeout waiting for transmitter busy to clear");
               errorCount++;
            end else if (!frameDone) begin
               $display("Transmitter busy cleared before the frame ended");
               errorCount++;
            end
         end
      join
      if (gotChar !== txChar) begin
         $display("Fail conTxd char: got %h expected %h", gotChar, txChar);
         errorCount++;
      end
      for (int i = 0; i < frameBits * clksPerBit; i++) begin
         idleCycle();
         if (conTxd !== 1'b1) begin
            $display("Second frame started on conTxd after a write while busy");
            errorCount++;
            break;
         end
      end
      finishTest("console transmit", errs);

      // 5 console receive
      errs   = errorCount;
      rxChar = 8'($urandom);
      sendFrame(rxChar);
      polls = 0;
      st    = '0;
      while (st[1] !== 1'b1 && polls < timeoutCycles) begin
         readReg(ioBaseCons + addrWidth'(consStatus), st);
         polls++;
      end
      if (st[1] !== 1'b1) begin
         $display("Timeout waiting for receive data valid");
         errorCount++;
      end
      issue(makeReq(1'b1, 1'b0, 1'b1, ioBaseCons + addrWidth'(consRxData), '0),
            1'b1, 1'b0, 1'b1, dataWidth'(rxChar));
      issue(makeReq(1'b1, 1'b0, 1'b1, ioBaseCons + addrWidth'(consStatus), '0),
            1'b1, 1'b0, 1'b1, '0);   // rx-valid cleared by the read
      idleCycle();
      lastRxChar = rxChar;
      finishTest("console receive", errs);

      // 6 every device, back to back
      errs = errorCount;
      for (int i = 0; i < 300; i++) begin
         kind = int'($urandom % 6);
         case (kind)
            0, 1: randomMemOp();
            2: randomUbaOp();
            3: begin
               off = ($urandom % 2 == 0) ? consRxData : consStatus;
               issue(makeReq(1'b1, 1'b0, 1'b1, ioBaseCons + addrWidth'(off), '0),
                     1'b1, 1'b0, 1'b1,
                     (off == consRxData) ? dataWidth'(lastRxChar) : '0);
            end
            4: randomNxmOp();
            default: randomUnmappedIo();
         endcase
      end
      idleCycle();
      idleCycle();
      finishTest("mixed back to back", errs);

      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               testCount, failedTests, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
design/ks10Pkg.sv
design/resetSync.sv
design/busArbiter.sv
design/memController.sv
design/consoleUart.sv
design/unibusAdapter.sv
design/ks10Top.sv
tests/busProtocol_asserts.sv
tests/ks10Tb.sv

// File: Makefile
SRCS := sources.f $(wildcard design/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vks10Tb: $(SRCS)
	verilator --binary --timing --assert --top-module ks10Tb -f sources.f -o Vks10Tb

run: obj_dir/Vks10Tb
	./obj_dir/Vks10Tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
